/* md_consts.svh */
/*
 * Constants of the multiply/divide unit
 * Data width, kernel half width, division step count and step counter width
 */

`ifndef MD_CONSTS_SVH
`define MD_CONSTS_SVH

// Operand and result width
`define MD_XLEN 32

// Kernel operand width without the extra sign bit
`define MD_HALF 16

// Compare iterations of the long division
`define MD_DIV_STEPS 32

// Step counter width, counts MD_DIV_STEPS - 1 down to 0
`define MD_CNT_W 5

`endif

/* md_pkg.sv */
/*
 * Types of the multiply/divide unit
 * Operation enum, request struct and per-unit result struct
 */

`default_nettype none

`include "md_consts.svh"

package md_pkg;

  typedef enum logic [1:0] {
    MD_OP_MUL  = 2'd0,
    MD_OP_MULH = 2'd1,
    MD_OP_DIV  = 2'd2,
    MD_OP_REM  = 2'd3
  } md_op_e;

  // Request seen by both units
  typedef struct packed {
    md_op_e              op;
    logic [1:0]          signed_mode;  // bit 0 for A, bit 1 for B
    logic [`MD_XLEN-1:0] op_a;
    logic [`MD_XLEN-1:0] op_b;
  } md_req_t;

  // Result of one unit, done is a single-cycle strobe
  typedef struct packed {
    logic                done;
    logic [`MD_XLEN-1:0] result;
  } md_res_t;

endpackage

`default_nettype wire

/* md_mult.sv */
/*
 * Sequential multiplier for MUL and MULH
 * One 17x17 signed multiply-accumulate kernel stepped over four partial products
 */

`default_nettype none

`include "md_consts.svh"

module md_mult
  import md_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    start_i,
  input  md_req_t req_i,
  output md_res_t res_o,
  output logic    busy_o
);

  typedef enum logic [1:0] {
    ALBL, ALBH, AHBL, AHBH
  } mult_state_e;

  mult_state_e state_q, state_d;

  logic        [2*`MD_HALF+1:0] acc_q, acc_d;
  logic        [2*`MD_HALF+1:0] accum;
  logic signed [2*`MD_HALF+1:0] mac;
  logic        [`MD_HALF-1:0]   kern_a;
  logic        [`MD_HALF-1:0]   kern_b;
  logic                         kern_sign_a;
  logic                         kern_sign_b;
  logic                         op_sign_a;
  logic                         op_sign_b;
  logic                         signed_mult;
  logic                         is_mulh;
  logic                         mul_start;
  logic                         done_q, done_d;

  assign mul_start   = start_i & (req_i.op inside {MD_OP_MUL, MD_OP_MULH});
  assign is_mulh     = (req_i.op == MD_OP_MULH);
  assign signed_mult = (req_i.signed_mode != 2'b00);
  assign op_sign_a   = req_i.signed_mode[0] & req_i.op_a[`MD_XLEN-1];
  assign op_sign_b   = req_i.signed_mode[1] & req_i.op_b[`MD_XLEN-1];

  // Bit 34 of the full sum always equals bit 33, so 34 bits are kept
  assign mac = $signed({kern_sign_a, kern_a}) * $signed({kern_sign_b, kern_b})
             + $signed(accum);

  always_comb begin
    kern_a      = req_i.op_a[`MD_HALF-1:0];
    kern_b      = req_i.op_b[`MD_HALF-1:0];
    kern_sign_a = 1'b0;
    kern_sign_b = 1'b0;
    accum       = '0;
    acc_d       = acc_q;
    state_d     = state_q;
    done_d      = 1'b0;

    unique case (state_q)
      ALBL: begin
        // al*bl, unsigned with no carry
        if (mul_start) begin
          acc_d   = $unsigned(mac);
          state_d = ALBH;
        end
      end

      ALBH: begin
        // al*bh shifted by the half width
        kern_b      = req_i.op_b[`MD_XLEN-1:`MD_HALF];
        kern_sign_b = op_sign_b;
        accum       = {{(`MD_HALF+2){1'b0}}, acc_q[`MD_XLEN-1:`MD_HALF]};
        if (is_mulh) begin
          acc_d = $unsigned(mac);
        end else begin
          acc_d = {2'b00, mac[`MD_HALF-1:0], acc_q[`MD_HALF-1:0]};
        end
        state_d = AHBL;
      end

      AHBL: begin
        // ah*bl shifted by the half width
        kern_a      = req_i.op_a[`MD_XLEN-1:`MD_HALF];
        kern_sign_a = op_sign_a;
        if (is_mulh) begin
          accum   = acc_q;
          acc_d   = $unsigned(mac);
          state_d = AHBH;
        end else begin
          accum   = {{(`MD_HALF+2){1'b0}}, acc_q[`MD_XLEN-1:`MD_HALF]};
          acc_d   = {2'b00, mac[`MD_HALF-1:0], acc_q[`MD_HALF-1:0]};
          done_d  = 1'b1;
          state_d = ALBL;
        end
      end

      AHBH: begin
        // ah*bh plus the upper part of the running sum
        kern_a      = req_i.op_a[`MD_XLEN-1:`MD_HALF];
        kern_b      = req_i.op_b[`MD_XLEN-1:`MD_HALF];
        kern_sign_a = op_sign_a;
        kern_sign_b = op_sign_b;
        accum       = {{`MD_HALF{signed_mult & acc_q[2*`MD_HALF+1]}},
                       acc_q[2*`MD_HALF+1:`MD_HALF]};
        acc_d       = $unsigned(mac);
        done_d      = 1'b1;
        state_d     = ALBL;
      end

      default: begin
        state_d = ALBL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ALBL;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    acc_q <= acc_d;
  end

  // Low word holds the product word selected by the operation
  assign res_o.done   = done_q;
  assign res_o.result = acc_q[`MD_XLEN-1:0];

  // Done cycle still counts as busy so the next start waits for the result stage
  assign busy_o = (state_q != ALBL) | done_q;

  a_state_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(state_q));

endmodule

`default_nettype wire

/* md_div.sv */
/*
 * Sequential divider for DIV and REM
 * Restoring long division with its own 33-bit subtractor and zero-divisor early finish
 */

`default_nettype none

`include "md_consts.svh"

module md_div
  import md_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    start_i,
  input  md_req_t req_i,
  output md_res_t res_o,
  output logic    busy_o
);

  typedef enum logic [2:0] {
    MD_IDLE, MD_ABS_A, MD_ABS_B, MD_COMP, MD_LAST, MD_CHANGE_SIGN, MD_FINISH
  } div_state_e;

  localparam logic [`MD_CNT_W-1:0] CNT_START = `MD_CNT_W'(`MD_DIV_STEPS - 1);

  div_state_e state_q, state_d;

  logic [`MD_XLEN-1:0]  rem_q, rem_d;
  logic [`MD_XLEN-1:0]  quot_q, quot_d;
  logic [`MD_XLEN-1:0]  num_q, num_d;
  logic [`MD_XLEN-1:0]  den_q, den_d;
  logic [`MD_CNT_W-1:0] cnt_q, cnt_d;
  logic [`MD_CNT_W-1:0] cnt_dec;
  logic                 done_q, done_d;

  logic [`MD_XLEN-1:0]  sub_a;
  logic [`MD_XLEN-1:0]  sub_b;
  logic [`MD_XLEN:0]    sub_res;
  logic                 is_ge;
  logic [`MD_XLEN-1:0]  next_rem;
  logic [`MD_XLEN-1:0]  next_quot;
  logic [`MD_XLEN-1:0]  one_shift;
  logic                 div_start;
  logic                 is_div;
  logic                 b_zero;
  logic                 sign_a;
  logic                 sign_b;
  logic                 quot_neg;

  assign div_start = start_i & (req_i.op inside {MD_OP_DIV, MD_OP_REM});
  assign is_div    = (req_i.op == MD_OP_DIV);
  assign b_zero    = (req_i.op_b == '0);
  assign sign_a    = req_i.signed_mode[0] & req_i.op_a[`MD_XLEN-1];
  assign sign_b    = req_i.signed_mode[1] & req_i.op_b[`MD_XLEN-1];
  assign quot_neg  = sign_a ^ sign_b;

  // Shared subtractor, the top bit is the borrow
  assign sub_res = {1'b0, sub_a} - {1'b0, sub_b};
  assign is_ge   = ~sub_res[`MD_XLEN];

  assign cnt_dec   = cnt_q - 1'b1;
  assign one_shift = {{(`MD_XLEN-1){1'b0}}, 1'b1} << cnt_q;
  assign next_rem  = is_ge ? sub_res[`MD_XLEN-1:0] : rem_q;
  assign next_quot = is_ge ? (quot_q | one_shift) : quot_q;

  always_comb begin
    state_d = state_q;
    rem_d   = rem_q;
    quot_d  = quot_q;
    num_d   = num_q;
    den_d   = den_q;
    cnt_d   = cnt_q;
    done_d  = 1'b0;
    sub_a   = '0;
    sub_b   = req_i.op_a;

    unique case (state_q)
      MD_IDLE: begin
        if (div_start) begin
          if (b_zero) begin
            // RISC-V results for a zero divisor, available after one cycle
            rem_d  = is_div ? '1 : req_i.op_a;
            done_d = 1'b1;
          end else begin
            state_d = MD_ABS_A;
          end
        end
      end

      MD_ABS_A: begin
        // |A| = 0 - A when negative
        sub_b   = req_i.op_a;
        num_d   = sign_a ? sub_res[`MD_XLEN-1:0] : req_i.op_a;
        quot_d  = '0;
        state_d = MD_ABS_B;
      end

      MD_ABS_B: begin
        sub_b   = req_i.op_b;
        den_d   = sign_b ? sub_res[`MD_XLEN-1:0] : req_i.op_b;
        rem_d   = {{(`MD_XLEN-1){1'b0}}, num_q[`MD_XLEN-1]};
        cnt_d   = CNT_START;
        state_d = MD_COMP;
      end

      MD_COMP: begin
        // Partial remainder stays below 2^31 here, so its top bit can be shifted out
        sub_a  = rem_q;
        sub_b  = den_q;
        rem_d  = {next_rem[`MD_XLEN-2:0], num_q[cnt_dec]};
        quot_d = next_quot;
        cnt_d  = cnt_dec;
        if (cnt_q == `MD_CNT_W'(1)) begin
          state_d = MD_LAST;
        end
      end

      MD_LAST: begin
        // Final step keeps only the word the operation returns
        sub_a   = rem_q;
        sub_b   = den_q;
        rem_d   = is_div ? next_quot : next_rem;
        state_d = MD_CHANGE_SIGN;
      end

      MD_CHANGE_SIGN: begin
        // Quotient takes the XOR of the signs, remainder the sign of A
        sub_b = rem_q;
        if (is_div ? quot_neg : sign_a) begin
          rem_d = sub_res[`MD_XLEN-1:0];
        end
        state_d = MD_FINISH;
      end

      MD_FINISH: begin
        done_d  = 1'b1;
        state_d = MD_IDLE;
      end

      default: begin
        state_d = MD_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= MD_IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      done_q  <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    rem_q  <= rem_d;
    quot_q <= quot_d;
    num_q  <= num_d;
    den_q  <= den_d;
  end

  assign res_o.done   = done_q;
  assign res_o.result = rem_q;
  assign busy_o       = (state_q != MD_IDLE) | done_q;

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {MD_IDLE, MD_ABS_A, MD_ABS_B, MD_COMP, MD_LAST, MD_CHANGE_SIGN, MD_FINISH});

  // Counter runs out in LAST and stays there until the next division
  a_idle_cnt_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == MD_IDLE) |-> (cnt_q == '0));

endmodule

`default_nettype wire

/* md_result_stage.sv */
/*
 * Result stage combining the multiplier and divider results
 * Holds the result until ready and derives the busy flag
 */

`default_nettype none

`include "md_consts.svh"

module md_result_stage
  import md_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  md_res_t             mult_res_i,
  input  md_res_t             div_res_i,
  input  logic                mult_busy_i,
  input  logic                div_busy_i,
  input  logic                ready_i,
  output logic                valid_o,
  output logic [`MD_XLEN-1:0] result_o,
  output logic                busy_o
);

  logic                valid_q;
  logic [`MD_XLEN-1:0] result_q;
  logic                any_done;

  assign any_done = mult_res_i.done | div_res_i.done;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (any_done) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mult_res_i.done) begin
      result_q <= mult_res_i.result;
    end else if (div_res_i.done) begin
      result_q <= div_res_i.result;
    end
  end

  assign valid_o  = valid_q;
  assign result_o = result_q;
  assign busy_o   = mult_busy_i | div_busy_i | valid_q;

  // Only one operation is in flight, so the units never finish together
  a_single_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(mult_res_i.done && div_res_i.done));

  // A held result is always taken before the next one arrives
  a_no_overwrite: assert property (@(posedge clk_i) disable iff (!rst_ni)
    any_done |-> !valid_q);

endmodule

`default_nettype wire

/* md_top.sv */
/*
 * Top level of the multiply/divide unit
 * Multiplier, divider and result stage sharing one busy gate
 */

`default_nettype none

`include "md_consts.svh"

module md_top
  import md_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  md_req_t             req_i,
  input  logic                ready_i,
  output logic                busy_o,
  output logic                valid_o,
  output logic [`MD_XLEN-1:0] result_o
);

  logic    start_gated;
  md_res_t mult_res;
  md_res_t div_res;
  logic    mult_busy;
  logic    div_busy;

  // Starts while an operation or a held result is pending are dropped
  assign start_gated = start_i & ~busy_o;

  md_mult u_mult (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (start_gated),
    .req_i   (req_i),
    .res_o   (mult_res),
    .busy_o  (mult_busy)
  );

  md_div u_div (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (start_gated),
    .req_i   (req_i),
    .res_o   (div_res),
    .busy_o  (div_busy)
  );

  md_result_stage u_result (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .mult_res_i  (mult_res),
    .div_res_i   (div_res),
    .mult_busy_i (mult_busy),
    .div_busy_i  (div_busy),
    .ready_i     (ready_i),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .busy_o      (busy_o)
  );

endmodule

`default_nettype wire

/* tb_md_top.sv */
/*
 * Self-checking testbench of the multiply/divide unit
 * Stimulus table with a reference model, random ready stalls and ignored starts
 */

`default_nettype none

`include "md_consts.svh"

module tb_md_top
  import md_pkg::*;
();

  localparam logic [31:0] SEED         = 32'hd112_bc8c;
  localparam int          MAX_STALL    = 6;
  localparam int          OP_CYCLES    = 45;
  localparam int          RESET_CYCLES = 5;
  localparam int          N_RANDOM     = 40;

  typedef struct packed {
    md_req_t             req;
    logic [`MD_XLEN-1:0] exp;
  } entry_t;

  logic                clk_i;
  logic                rst_ni;
  logic                start_i;
  md_req_t             req_i;
  logic                ready_i;
  logic                busy_o;
  logic                valid_o;
  logic [`MD_XLEN-1:0] result_o;

  entry_t test_q[$];
  int     cycle_cnt   = 0;
  int     cycle_limit = 0;
  int     cur_idx     = 0;

  md_top dut (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start_i),
    .req_i    (req_i),
    .ready_i  (ready_i),
    .busy_o   (busy_o),
    .valid_o  (valid_o),
    .result_o (result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: no finished result after %0d cycles at entry %0d", cycle_cnt, cur_idx);
      $display("TEST FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  // RISC-V M rules with each operand signed or unsigned on its own
  function automatic logic [`MD_XLEN-1:0] model_result(input md_req_t req);
    logic                  neg_a;
    logic                  neg_b;
    logic [2*`MD_XLEN-1:0] prod;
    logic [`MD_XLEN-1:0]   mag_a;
    logic [`MD_XLEN-1:0]   mag_b;
    logic [`MD_XLEN-1:0]   quot;
    logic [`MD_XLEN-1:0]   rem;
    logic [`MD_XLEN-1:0]   res;

    neg_a = req.signed_mode[0] & req.op_a[`MD_XLEN-1];
    neg_b = req.signed_mode[1] & req.op_b[`MD_XLEN-1];
    // Low 64 bits of the extended product are exact for any mix of signs
    prod  = {{`MD_XLEN{neg_a}}, req.op_a} * {{`MD_XLEN{neg_b}}, req.op_b};
    mag_a = neg_a ? -req.op_a : req.op_a;
    mag_b = neg_b ? -req.op_b : req.op_b;
    if (req.op_b == '0) begin
      quot = '1;
      rem  = req.op_a;
    end else begin
      quot = mag_a / mag_b;
      rem  = mag_a % mag_b;
      if (neg_a ^ neg_b) begin
        quot = -quot;
      end
      if (neg_a) begin
        rem = -rem;
      end
    end
    case (req.op)
      MD_OP_MUL:  res = prod[`MD_XLEN-1:0];
      MD_OP_MULH: res = prod[2*`MD_XLEN-1:`MD_XLEN];
      MD_OP_DIV:  res = quot;
      default:    res = rem;
    endcase
    return res;
  endfunction

  task automatic add_entry(input md_op_e op, input logic [1:0] mode,
                           input logic [`MD_XLEN-1:0] a, input logic [`MD_XLEN-1:0] b);
    entry_t e;

    e.req.op          = op;
    e.req.signed_mode = mode;
    e.req.op_a        = a;
    e.req.op_b        = b;
    e.exp             = model_result(e.req);
    test_q.push_back(e);
  endtask

  task automatic check_result(input string name, input logic [`MD_XLEN-1:0] exp_val,
                              input logic [`MD_XLEN-1:0] act_val);
    if (act_val !== exp_val) begin
      $display("error %s: expected %h, got %h at entry %0d", name, exp_val, act_val, cur_idx);
      $display("TEST FAIL");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      $display("error %s: expected %h, got %h at entry %0d", name, exp_val, act_val, cur_idx);
      $display("TEST FAIL");
      $fatal(1, "flag mismatch");
    end
  endtask

  initial begin
    entry_t              e;
    md_req_t             alt;
    logic [`MD_XLEN-1:0] b;
    int                  stall;
    int                  pick;
    int                  i;
    int                  s;

    rst_ni  = 1'b0;
    start_i = 1'b0;
    req_i   = '0;
    ready_i = 1'b0;
    void'($urandom(SEED));

    // Multiplication in all signed modes
    add_entry(MD_OP_MUL,  2'b00, 32'd7,          32'd6);
    add_entry(MD_OP_MUL,  2'b11, 32'hffff_fffb, 32'd3);
    add_entry(MD_OP_MUL,  2'b01, 32'h8000_0001, 32'hffff_ffff);
    add_entry(MD_OP_MULH, 2'b11, 32'h8000_0000, 32'h8000_0000);
    add_entry(MD_OP_MULH, 2'b00, 32'hffff_ffff, 32'hffff_ffff);
    add_entry(MD_OP_MULH, 2'b01, 32'hffff_ffff, 32'hffff_ffff);
    add_entry(MD_OP_MULH, 2'b10, 32'h1234_5678, 32'h8000_0000);
    add_entry(MD_OP_MULH, 2'b11, 32'hffff_fffd, 32'd7);
    // Division with negative operands and overflow
    add_entry(MD_OP_DIV,  2'b11, 32'hffff_ff9c, 32'd7);
    add_entry(MD_OP_REM,  2'b11, 32'hffff_ff9c, 32'd7);
    add_entry(MD_OP_DIV,  2'b11, 32'd100,        32'hffff_fff9);
    add_entry(MD_OP_REM,  2'b11, 32'd100,        32'hffff_fff9);
    add_entry(MD_OP_DIV,  2'b00, 32'hffff_ffff, 32'd3);
    add_entry(MD_OP_REM,  2'b01, 32'hffff_ff9c, 32'd7);
    add_entry(MD_OP_DIV,  2'b11, 32'h8000_0000, 32'hffff_ffff);
    add_entry(MD_OP_REM,  2'b11, 32'h8000_0000, 32'hffff_ffff);
    // Zero divisor
    add_entry(MD_OP_DIV,  2'b11, 32'd5,          32'd0);
    add_entry(MD_OP_REM,  2'b11, 32'hffff_fffb, 32'd0);
    add_entry(MD_OP_DIV,  2'b00, 32'd0,          32'd0);

    for (i = 0; i < N_RANDOM; i++) begin
      pick = $urandom_range(0, 3);
      b    = $urandom();
      if (pick == 0) begin
        b = '0;
      end else if (pick == 1) begin
        b = $urandom_range(1, 15);
      end
      add_entry(md_op_e'(2'($urandom_range(0, 3))), 2'($urandom_range(0, 3)), $urandom(), b);
    end

    cycle_limit = test_q.size() * (OP_CYCLES + MAX_STALL) + RESET_CYCLES + 20;

    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (i = 0; i < test_q.size(); i++) begin
      e       = test_q[i];
      cur_idx = i;
      // Unit idle and nothing held just as after reset
      @(negedge clk_i);
      check_flag("valid_o", 1'b0, valid_o);
      check_flag("busy_o", 1'b0, busy_o);
      @(posedge clk_i);
      req_i   <= e.req;
      start_i <= 1'b1;
      @(posedge clk_i);
      start_i <= 1'b0;
      @(negedge clk_i);
      while (!valid_o) begin
        check_flag("busy_o", 1'b1, busy_o);
        @(negedge clk_i);
      end
      check_result("result_o", e.exp, result_o);

      // Hold ready low and try a different request while the result waits
      stall    = $urandom_range(0, MAX_STALL);
      alt      = e.req;
      alt.op   = md_op_e'(e.req.op ^ 2'b10);
      alt.op_a = ~e.req.op_a;
      alt.op_b = e.req.op_b ^ 32'h0000_ffff;
      for (s = 0; s < stall; s++) begin
        @(posedge clk_i);
        if (s == 0) begin
          req_i   <= alt;
          start_i <= 1'b1;
        end else begin
          start_i <= 1'b0;
        end
        @(negedge clk_i);
        check_flag("valid_o", 1'b1, valid_o);
        check_flag("busy_o", 1'b1, busy_o);
        check_result("result_o", e.exp, result_o);
      end
      @(posedge clk_i);
      start_i <= 1'b0;
      ready_i <= 1'b1;
      @(posedge clk_i);
      ready_i <= 1'b0;
      @(negedge clk_i);
      check_flag("valid_o", 1'b0, valid_o);
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
md_pkg.sv
md_mult.sv
md_div.sv
md_result_stage.sv
md_top.sv
tb_md_top.sv

/* run.sh */
#!/bin/sh
# Build and run the multiply/divide testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_md_top -o tb_md_top
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_md_top
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation ended with status $status"
  exit "$status"
fi

exit 0
